// File: include/cache_macros.svh
// ##########################################################
// Cache geometry and bus widths for the two-way data cache
// ##########################################################
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Geometry
`define CACHE_WAYS 2
`define CACHE_SETS 256
`define INDEX_W    8
`define TAG_W      20
`define OFFSET_W   4
`define BANKS      4

// Data path
`define WORD_W     32
`define STRB_W     4

// Replacement
`define LFSR_SEED  3'b111

`endif

// File: src/cache_pkg.sv
// ##########################################################
// Address, tag and line types of the data cache
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`WORD_W-1:0]  word_t;
    typedef word_t [`BANKS-1:0]  line_t;   // Bank 0 sits in the low word

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic [1:0] bank;       // Word within the line
        logic [1:0] byte_off;
    } addr_fields_t;

    // Same 32 bits seen as fields in the cache and as a flat bus address
    typedef union packed {
        addr_fields_t f;
        logic [31:0]  flat;
    } cache_addr_u;

endpackage

`default_nettype wire

// File: src/bus_pkg.sv
// ##########################################################
// CPU operation and bus request encodings
// ##########################################################
`default_nettype none

package bus_pkg;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } op_e;

    // Shared by rd_type and wr_type
    typedef enum logic [2:0] {
        BYTE  = 3'b000,
        HALF  = 3'b001,
        WORD  = 3'b010,
        BLOCK = 3'b100
    } req_type_e;

endpackage

`default_nettype wire

// File: src/tag_store.sv
// ##########################################################
// Tags with valid and dirty bits for both ways
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module tag_store (
    input  wire                                clk,
    input  wire                                resetn,
    input  wire                                rd_en,
    input  wire cache_pkg::index_t             rd_index,
    output cache_pkg::tag_t [`CACHE_WAYS-1:0]  way_tag,
    output logic [`CACHE_WAYS-1:0]             way_valid,
    output logic [`CACHE_WAYS-1:0]             way_dirty,
    input  wire                                fill_en,
    input  wire                                fill_way,
    input  wire cache_pkg::index_t             fill_index,
    input  wire cache_pkg::tag_t               fill_tag,
    input  wire                                fill_dirty,
    input  wire                                mark_en,
    input  wire                                mark_way,
    input  wire cache_pkg::index_t             mark_index
);

    cache_pkg::tag_t tags [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_bits;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_bits;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_way][fill_index] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (fill_en) begin
                valid_bits[fill_way][fill_index] <= 1'b1;
                dirty_bits[fill_way][fill_index] <= fill_dirty;   // Write miss fills dirty
            end
            if (mark_en) begin
                dirty_bits[mark_way][mark_index] <= 1'b1;         // Write hit
            end
        end
    end

    // Read result holds until the next lookup
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                way_tag[w]   <= tags[w][rd_index];
                way_valid[w] <= valid_bits[w][rd_index];
                way_dirty[w] <= dirty_bits[w][rd_index];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/data_store.sv
// ##########################################################
// Banked data arrays, byte-masked word writes, line reads
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module data_store (
    input  wire                                 clk,
    input  wire                                 rd_en,
    input  wire cache_pkg::index_t              rd_index,
    output cache_pkg::line_t [`CACHE_WAYS-1:0]  way_line,
    input  wire                                 wr_en,
    input  wire                                 wr_way,
    input  wire cache_pkg::index_t              wr_index,
    input  wire [1:0]                           wr_bank,
    input  wire [`STRB_W-1:0]                   wr_strb,
    input  wire cache_pkg::word_t               wr_word
);

    // One array per way and bank
    cache_pkg::word_t mem [`CACHE_WAYS][`BANKS][`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_way][wr_bank][wr_index][i*8 +: 8] <= wr_word[i*8 +: 8];
                end
            end
        end
    end

    // All banks of both ways at once so a victim line is ready for write-back
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                for (int b = 0; b < `BANKS; b++) begin
                    way_line[w][b] <= mem[w][b][rd_index];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/lookup_stage.sv
// ##########################################################
// Lookup stage with request buffer, hit compare and CPU response
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module lookup_stage (
    input  wire                                 clk,
    input  wire                                 resetn,
    input  wire                                 valid,
    input  wire bus_pkg::op_e                   op,
    input  wire cache_pkg::index_t              index,
    input  wire cache_pkg::tag_t                tag,
    input  wire [`OFFSET_W-1:0]                 offset,
    input  wire [`STRB_W-1:0]                   wstrb,
    input  wire cache_pkg::word_t               wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output cache_pkg::word_t                    rdata,
    output logic                                rd_en,
    output cache_pkg::index_t                   rd_index,
    input  wire cache_pkg::tag_t [`CACHE_WAYS-1:0]  way_tag,
    input  wire [`CACHE_WAYS-1:0]               way_valid,
    input  wire cache_pkg::line_t [`CACHE_WAYS-1:0] way_line,
    output logic                                mark_en,
    output logic                                mark_way,
    output cache_pkg::index_t                   mark_index,
    output logic                                hit_wr_en,
    output logic                                hit_wr_way,
    output logic [1:0]                          hit_wr_bank,
    output logic [`STRB_W-1:0]                  hit_wr_strb,
    output cache_pkg::word_t                    hit_wr_word,
    output logic                                miss_start,
    output cache_pkg::cache_addr_u              req_addr,
    output bus_pkg::op_e                        req_op,
    output logic [`STRB_W-1:0]                  req_wstrb,
    output cache_pkg::word_t                    req_wdata,
    input  wire                                 refill_data_ok,
    input  wire cache_pkg::word_t               refill_word,
    input  wire                                 miss_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT     // Miss handled by miss_ctrl
    } state_e;

    state_e                 state;
    logic                   accept;
    logic                   in_lookup;
    logic [`CACHE_WAYS-1:0] way_hit;
    logic                   hit;
    logic                   hit_way;
    logic                   write_hit;

    assign accept    = (state == ST_IDLE) && valid;
    assign in_lookup = (state == ST_LOOKUP);

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = way_valid[w] && (way_tag[w] == req_addr.f.tag);
        end
    end

    assign hit       = |way_hit;
    assign hit_way   = way_hit[1];
    assign write_hit = in_lookup && hit && (req_op == bus_pkg::WRITE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (valid) state <= ST_LOOKUP;
                ST_LOOKUP: state <= hit ? ST_IDLE : ST_WAIT;
                ST_WAIT:   if (miss_done) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Held for the whole miss
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr.flat <= {tag, index, offset};
            req_op        <= op;
            req_wstrb     <= wstrb;
            req_wdata     <= wdata;
        end
    end

    // Store read goes out on the accept edge
    assign addr_ok  = (state == ST_IDLE);
    assign rd_en    = accept;
    assign rd_index = index;

    // Writes are answered at once even on a miss
    assign data_ok = (in_lookup && (hit || req_op == bus_pkg::WRITE)) || refill_data_ok;
    assign rdata   = in_lookup ? way_line[hit_way][req_addr.f.bank] : refill_word;

    assign hit_wr_en   = write_hit;
    assign hit_wr_way  = hit_way;
    assign hit_wr_bank = req_addr.f.bank;
    assign hit_wr_strb = req_wstrb;
    assign hit_wr_word = req_wdata;

    assign mark_en    = write_hit;
    assign mark_way   = hit_way;
    assign mark_index = req_addr.f.index;   // Also the hit write index

    assign miss_start = in_lookup && !hit;

endmodule

`default_nettype wire

// File: src/miss_ctrl.sv
// ##########################################################
// Miss handling with victim choice, write-back and line refill
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module miss_ctrl (
    input  wire                                 clk,
    input  wire                                 resetn,
    input  wire                                 miss_start,
    input  wire cache_pkg::cache_addr_u         req_addr,
    input  wire bus_pkg::op_e                   req_op,
    input  wire [`STRB_W-1:0]                   req_wstrb,
    input  wire cache_pkg::word_t               req_wdata,
    input  wire cache_pkg::tag_t [`CACHE_WAYS-1:0]  way_tag,
    input  wire [`CACHE_WAYS-1:0]               way_valid,
    input  wire [`CACHE_WAYS-1:0]               way_dirty,
    input  wire cache_pkg::line_t [`CACHE_WAYS-1:0] way_line,
    output logic                                rd_req,
    output bus_pkg::req_type_e                  rd_type,
    output logic [31:0]                         rd_addr,
    input  wire                                 rd_rdy,
    input  wire                                 ret_valid,
    input  wire                                 ret_last,
    input  wire cache_pkg::word_t               ret_data,
    output logic                                wr_req,
    output bus_pkg::req_type_e                  wr_type,
    output logic [31:0]                         wr_addr,
    output logic [`STRB_W-1:0]                  wr_wstrb,
    output cache_pkg::line_t                    wr_data,
    input  wire                                 wr_rdy,
    output logic                                fill_en,
    output logic                                fill_way,
    output cache_pkg::index_t                   fill_index,
    output cache_pkg::tag_t                     fill_tag,
    output logic                                fill_dirty,
    output logic                                refill_wr_en,
    output logic                                refill_wr_way,
    output cache_pkg::index_t                   refill_wr_index,
    output logic [1:0]                          refill_wr_bank,
    output logic [`STRB_W-1:0]                  refill_wr_strb,
    output cache_pkg::word_t                    refill_wr_word,
    output logic                                refill_data_ok,
    output cache_pkg::word_t                    refill_word,
    output logic                                miss_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MISS,        // Victim write-back
        ST_REPLACE,     // Line read request
        ST_REFILL
    } state_e;

    state_e                 state;
    logic [2:0]             lfsr;
    logic                   victim_q;
    logic                   victim;
    logic                   victim_dirty;
    logic                   miss_exit;
    logic [1:0]             beat_cnt;
    logic                   beat;
    logic                   crit_beat;
    cache_pkg::word_t       merged_word;
    cache_pkg::cache_addr_u line_addr;
    cache_pkg::cache_addr_u victim_addr;

    assign victim       = (state == ST_MISS) ? lfsr[0] : victim_q;
    assign victim_dirty = way_valid[victim] && way_dirty[victim];
    assign miss_exit    = (state == ST_MISS) && (wr_rdy || !victim_dirty);
    assign beat         = (state == ST_REFILL) && ret_valid;
    assign crit_beat    = beat && (beat_cnt == req_addr.f.bank);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= ST_IDLE;
            lfsr     <= `LFSR_SEED;
            victim_q <= 1'b0;
            beat_cnt <= 2'd0;
        end else begin
            case (state)
                ST_IDLE:    if (miss_start) state <= ST_MISS;
                ST_MISS:    if (miss_exit) state <= ST_REPLACE;
                ST_REPLACE: if (rd_rdy) state <= ST_REFILL;
                ST_REFILL:  if (ret_valid && ret_last) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
            if (miss_exit) begin
                victim_q <= lfsr[0];
            end
            if (state == ST_REPLACE) begin
                beat_cnt <= 2'd0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 2'd1;    // Gaps simply stall the count
            end
            if (beat && ret_last) begin
                lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};   // Period 7 sequence
            end
        end
    end

    // On a write miss the store data lands in the critical word as it arrives
    always_comb begin
        merged_word = ret_data;
        if (req_op == bus_pkg::WRITE && beat_cnt == req_addr.f.bank) begin
            for (int i = 0; i < `STRB_W; i++) begin
                if (req_wstrb[i]) begin
                    merged_word[i*8 +: 8] = req_wdata[i*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        line_addr            = req_addr;
        line_addr.f.bank     = 2'd0;
        line_addr.f.byte_off = 2'd0;
        victim_addr          = line_addr;
        victim_addr.f.tag    = way_tag[victim];
    end

    assign rd_req  = (state == ST_REPLACE);
    assign rd_type = bus_pkg::BLOCK;
    assign rd_addr = line_addr.flat;

    assign wr_req   = (state == ST_MISS) && victim_dirty;
    assign wr_type  = bus_pkg::BLOCK;
    assign wr_addr  = victim_addr.flat;
    assign wr_wstrb = '1;
    assign wr_data  = way_line[victim];

    // Tag goes in with the critical word
    assign fill_en    = crit_beat;
    assign fill_way   = victim;
    assign fill_index = req_addr.f.index;
    assign fill_tag   = req_addr.f.tag;
    assign fill_dirty = (req_op == bus_pkg::WRITE);

    assign refill_wr_en    = beat;
    assign refill_wr_way   = victim;
    assign refill_wr_index = req_addr.f.index;
    assign refill_wr_bank  = beat_cnt;
    assign refill_wr_strb  = '1;
    assign refill_wr_word  = merged_word;

    assign refill_data_ok = crit_beat && (req_op == bus_pkg::READ);
    assign refill_word    = merged_word;
    assign miss_done      = beat && ret_last;

endmodule

`default_nettype wire

// File: src/cache_top.sv
// ##########################################################
// Data cache top with lookup and miss stages beside the stores
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module cache_top (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        valid,
    input  wire bus_pkg::op_e          op,
    input  wire cache_pkg::index_t     index,
    input  wire cache_pkg::tag_t       tag,
    input  wire [`OFFSET_W-1:0]        offset,
    input  wire [`STRB_W-1:0]          wstrb,
    input  wire cache_pkg::word_t      wdata,
    output logic                       addr_ok,
    output logic                       data_ok,
    output cache_pkg::word_t           rdata,
    output logic                       rd_req,
    output bus_pkg::req_type_e         rd_type,
    output logic [31:0]                rd_addr,
    input  wire                        rd_rdy,
    input  wire                        ret_valid,
    input  wire                        ret_last,
    input  wire cache_pkg::word_t      ret_data,
    output logic                       wr_req,
    output bus_pkg::req_type_e         wr_type,
    output logic [31:0]                wr_addr,
    output logic [`STRB_W-1:0]         wr_wstrb,
    output cache_pkg::line_t           wr_data,
    input  wire                        wr_rdy
);

    // Store read side
    logic                                rd_en;
    cache_pkg::index_t                   rd_index;
    cache_pkg::tag_t [`CACHE_WAYS-1:0]   way_tag;
    logic [`CACHE_WAYS-1:0]              way_valid;
    logic [`CACHE_WAYS-1:0]              way_dirty;
    cache_pkg::line_t [`CACHE_WAYS-1:0]  way_line;

    // Tag store writes
    logic                                fill_en;
    logic                                fill_way;
    cache_pkg::index_t                   fill_index;
    cache_pkg::tag_t                     fill_tag;
    logic                                fill_dirty;
    logic                                mark_en;
    logic                                mark_way;
    cache_pkg::index_t                   mark_index;

    // Data store writers
    logic                                hit_wr_en;
    logic                                hit_wr_way;
    logic [1:0]                          hit_wr_bank;
    logic [`STRB_W-1:0]                  hit_wr_strb;
    cache_pkg::word_t                    hit_wr_word;
    logic                                refill_wr_en;
    logic                                refill_wr_way;
    cache_pkg::index_t                   refill_wr_index;
    logic [1:0]                          refill_wr_bank;
    logic [`STRB_W-1:0]                  refill_wr_strb;
    cache_pkg::word_t                    refill_wr_word;

    // Stage handoff
    logic                                miss_start;
    cache_pkg::cache_addr_u              req_addr;
    bus_pkg::op_e                        req_op;
    logic [`STRB_W-1:0]                  req_wstrb;
    cache_pkg::word_t                    req_wdata;
    logic                                refill_data_ok;
    cache_pkg::word_t                    refill_word;
    logic                                miss_done;

    tag_store u_tag_store (.*);

    // Hit write and refill never overlap so a plain select merges them
    data_store u_data_store (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .way_line (way_line),
        .wr_en    (hit_wr_en | refill_wr_en),
        .wr_way   (refill_wr_en ? refill_wr_way   : hit_wr_way),
        .wr_index (refill_wr_en ? refill_wr_index : mark_index),
        .wr_bank  (refill_wr_en ? refill_wr_bank  : hit_wr_bank),
        .wr_strb  (refill_wr_en ? refill_wr_strb  : hit_wr_strb),
        .wr_word  (refill_wr_en ? refill_wr_word  : hit_wr_word)
    );

    lookup_stage u_lookup_stage (.*);

    miss_ctrl u_miss_ctrl (.*);

endmodule

`default_nettype wire

// File: tests/cache_checker.sv
// ##########################################################
// Watches the cache ports and checks them against a shadow memory
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module cache_checker #(
    parameter logic [31:0] fill_key = 32'h0
) (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         valid,
    input  wire bus_pkg::op_e           op,
    input  wire cache_pkg::index_t      index,
    input  wire cache_pkg::tag_t        tag,
    input  wire [`OFFSET_W-1:0]         offset,
    input  wire [`STRB_W-1:0]           wstrb,
    input  wire cache_pkg::word_t       wdata,
    input  wire                         addr_ok,
    input  wire                         data_ok,
    input  wire cache_pkg::word_t       rdata,
    input  wire                         rd_req,
    input  wire bus_pkg::req_type_e     rd_type,
    input  wire [31:0]                  rd_addr,
    input  wire                         rd_rdy,
    input  wire                         wr_req,
    input  wire bus_pkg::req_type_e     wr_type,
    input  wire [31:0]                  wr_addr,
    input  wire [`STRB_W-1:0]           wr_wstrb,
    input  wire cache_pkg::line_t       wr_data,
    input  wire                         wr_rdy,
    output int                          error_count,
    output int                          check_count,
    output int                          outstanding
);

    logic [31:0]      shadow [logic [29:0]];   // CPU view of memory
    logic             in_reset_q;
    logic             pending;
    bus_pkg::op_e     pend_op;
    cache_pkg::word_t pend_word;
    logic [31:0]      pend_addr;
    int               pend_age;

    // Expected word at any address
    // Untouched words keep the fill pattern
    function automatic cache_pkg::word_t expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ fill_key;
    endfunction

    function automatic cache_pkg::word_t apply_strobes(input cache_pkg::word_t old_word,
                                                       input cache_pkg::word_t new_word,
                                                       input logic [`STRB_W-1:0] strb);
        cache_pkg::word_t result;
        result = old_word;
        for (int i = 0; i < `STRB_W; i++) begin
            if (strb[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return result;
    endfunction

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp, input logic [31:0] addr);
        error_count++;
        $display("[FAIL] %0t: %s at %h, got %h, expected %h", $time, what, addr, got, exp);
    endtask

    task automatic report_protocol(input string what);
        error_count++;
        $display("Protocol error at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        logic [31:0] addr;
        if (!resetn) begin
            error_count = 0;
            check_count = 0;
            outstanding = 0;
            pending     = 1'b0;
            pend_age    = 0;
            in_reset_q  = 1'b1;
        end else begin
            if (in_reset_q === 1'b1) begin   // First cycle out of reset
                check_count++;
                if (addr_ok !== 1'b1 || data_ok !== 1'b0 || rd_req !== 1'b0 || wr_req !== 1'b0)
                    report_protocol("outputs not in their idle state after reset");
            end
            in_reset_q = 1'b0;
            if ((rd_req || wr_req) && addr_ok)
                report_protocol("bus request while the cache is idle");
            if (rd_req && rd_rdy) begin
                check_count++;
                if (rd_addr[`OFFSET_W-1:0] != '0 || rd_type != bus_pkg::BLOCK)
                    report_protocol("line read with a bad address or type");
            end
            if (wr_req && wr_rdy) begin
                check_count++;
                if (wr_addr[`OFFSET_W-1:0] != '0 || wr_type != bus_pkg::BLOCK || wr_wstrb != '1)
                    report_protocol("write-back with a bad address, type or strobe");
                for (int b = 0; b < `BANKS; b++) begin
                    addr = wr_addr + 32'(b * 4);
                    if (wr_data[b] !== expected_word(addr))
                        report_value("write-back word", wr_data[b], expected_word(addr), addr);
                end
            end
            if (pending) pend_age++;
            if (data_ok) begin
                check_count++;
                if (!pending) begin
                    report_protocol("data_ok with no request outstanding");
                end else begin
                    if (pend_op == bus_pkg::READ && rdata !== pend_word)
                        report_value("read data", rdata, pend_word, pend_addr);
                    pending = 1'b0;
                end
            end else if (pending && pend_op == bus_pkg::WRITE && pend_age >= 1) begin
                report_protocol("write got no data_ok in the cycle after acceptance");
                pending = 1'b0;
            end
            if (valid && addr_ok) begin
                addr = {tag, index, offset};
                if (pending)
                    report_protocol("request accepted before the previous one got data_ok");
                if (op == bus_pkg::WRITE)
                    shadow[addr[31:2]] = apply_strobes(expected_word(addr), wdata, wstrb);
                pending   = 1'b1;
                pend_op   = op;
                pend_addr = addr;
                pend_word = expected_word(addr);   // Value is fixed at accept
                pend_age  = 0;
            end
            outstanding = pending ? 1 : 0;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_cache.sv
// ##########################################################
// Testbench for the two-way data cache with random CPU requests
// and a bus memory with random back-pressure
// ##########################################################
`default_nettype none
`include "cache_macros.svh"

module tb_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          num_requests       = 400;
    localparam int          cycles_per_request = 60;
    localparam int          max_cycles         = num_requests * cycles_per_request;
    localparam logic [31:0] fill_key           = 32'h5a3c_96e1;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 valid;
    bus_pkg::op_e         op;
    cache_pkg::index_t    index;
    cache_pkg::tag_t      tag;
    logic [`OFFSET_W-1:0] offset;
    logic [`STRB_W-1:0]   wstrb;
    cache_pkg::word_t     wdata;
    logic                 addr_ok;
    logic                 data_ok;
    cache_pkg::word_t     rdata;
    logic                 rd_req;
    bus_pkg::req_type_e   rd_type;
    logic [31:0]          rd_addr;
    logic                 rd_rdy = 1'b0;
    logic                 ret_valid = 1'b0;
    logic                 ret_last = 1'b0;
    cache_pkg::word_t     ret_data = '0;
    logic                 wr_req;
    bus_pkg::req_type_e   wr_type;
    logic [31:0]          wr_addr;
    logic [`STRB_W-1:0]   wr_wstrb;
    cache_pkg::line_t     wr_data;
    logic                 wr_rdy = 1'b0;

    int                   error_count;
    int                   check_count;
    int                   outstanding;
    int                   cycle_count;
    integer               seed = 83;
    integer               bus_seed;

    logic [31:0]          bus_mem [logic [29:0]];   // Only written-back words
    logic                 returning;
    logic [1:0]           beat_idx;
    logic [31:0]          refill_base;

    always #4 clk = ~clk;

    cache_top UUT (.*);

    cache_checker #(.fill_key(fill_key)) u_checker (.*);

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (bus_mem.exists(addr[31:2])) begin
            return bus_mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ fill_key;
    endfunction

    // Bus memory model
    always @(posedge clk) begin
        logic [29:0] key;
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            returning <= 1'b0;
            beat_idx  <= 2'd0;
        end else begin
            rd_rdy    <= ($random(bus_seed) & 3) != 0;
            wr_rdy    <= ($random(bus_seed) & 3) != 0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (wr_req && wr_rdy) begin
                for (int b = 0; b < `BANKS; b++) begin
                    key = wr_addr[31:2] + 30'(b);
                    bus_mem[key] = wr_data[b];
                end
            end
            if (rd_req && rd_rdy) begin
                refill_base <= rd_addr;
                beat_idx    <= 2'd0;
                returning   <= 1'b1;
            end else if (returning && (($random(bus_seed) & 1) != 0)) begin   // Random gaps
                ret_valid <= 1'b1;
                ret_last  <= (beat_idx == 2'd3);
                ret_data  <= mem_word(refill_base + {28'd0, beat_idx, 2'b00});
                beat_idx  <= beat_idx + 2'd1;
                returning <= (beat_idx != 2'd3);
            end
        end
    end

    // Holds the request until addr_ok takes it
    task automatic issue_request();
        @(posedge clk);
        valid  <= 1'b1;
        op     <= (($random(seed) & 1) != 0) ? bus_pkg::WRITE : bus_pkg::READ;
        index  <= cache_pkg::index_t'($unsigned($random(seed)) % 4);
        tag    <= cache_pkg::tag_t'($unsigned($random(seed)) % 6);
        offset <= {2'($random(seed)), 2'b00};
        wstrb  <= `STRB_W'($random(seed));
        wdata  <= $random(seed);
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic report_result();
        int total;
        total = error_count;
        if (outstanding != 0) begin
            $display("A request was left without its data_ok response");
            total = total + 1;
        end
        $display("Checks: %0d, errors: %0d", check_count, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
    endtask

    initial begin
        bus_seed = seed + 1;
        resetn   = 1'b0;
        valid    = 1'b0;
        op       = bus_pkg::READ;
        index    = '0;
        tag      = '0;
        offset   = '0;
        wstrb    = '0;
        wdata    = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        for (int n = 0; n < num_requests; n++) begin
            if (($random(seed) & 7) == 0) @(posedge clk);
            issue_request();
        end
        @(posedge clk);
        while (!addr_ok) @(posedge clk);   // Last request finished
        repeat (2) @(posedge clk);
        @(negedge clk);
        report_result();
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
src/cache_pkg.sv
src/bus_pkg.sv
src/tag_store.sv
src/data_store.sv
src/lookup_stage.sv
src/miss_ctrl.sv
src/cache_top.sv
tests/cache_checker.sv
tests/tb_cache.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module tb_cache -o tb_cache > build.log 2>&1 \
    && ./obj_dir/tb_cache > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not run to the end"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation finished without errors"
exit 0
